// File: aqp_defines.svh
`ifndef AQP_DEFINES_SVH
`define AQP_DEFINES_SVH

// I/O port numbers, low address byte with iorq_n low
`define AQP_IO_DAC          8'hEC   // Audio DAC
`define AQP_IO_BANK_BASE    8'hF0   // Page registers F0..F3
`define AQP_IO_ESPCTRL      8'hF4   // UART status / control
`define AQP_IO_ESPDATA      8'hF5   // UART data
`define AQP_IO_SYSCTRL      8'hFB
`define AQP_IO_CASSETTE     8'hFC
`define AQP_IO_PRINTER      8'hFE
`define AQP_IO_KEYB         8'hFF   // Keyboard matrix read

// Page number decode
// Pages 16..19 go to the cartridge slot
`define AQP_PAGE_CART_HI    4'b0100

// Overlay window $3800-$3FFF inside a quarter
`define AQP_SYSRAM_BLK      3'b111

// Audio
`define AQP_BEEP_LEVEL      10'd1023  // Beep amplitude in mixer units

`endif

// File: bus_pkg.sv
`default_nettype none

package bus_pkg;

    // CPU address and data
    typedef logic [15:0] addr_t;
    typedef logic [7:0]  data_t;

    // One of 64 16 KB pages
    typedef logic [5:0]  page_t;

    // Page register layout
    //   bit 7     read-only
    //   bit 6     overlay (system RAM write exception)
    //   bits 5..0 page number
    typedef logic [7:0]  bank_reg_t;

    // CPU bus cycle as seen from the board
    typedef struct packed {
        addr_t addr;
        data_t wrdata;
        logic  rd_n;
        logic  wr_n;
        logic  mreq_n;
        logic  iorq_n;
        logic  stb;     // Sampling strobe from bus sync logic
    } bus_req_t;

    // External memory control
    typedef struct packed {
        logic [4:0] ba;         // Bank address to 512 KB RAM / cart
        logic       ram_ce_n;
        logic       cart_ce_n;
        logic       ram_we_n;
    } mem_ctrl_t;

endpackage

`default_nettype wire

// File: periph_pkg.sv
`default_nettype none

package periph_pkg;

    // System control, reads back in bits 3..0 of port FB
    typedef struct packed {
        logic turbo_unlimited;
        logic turbo;
        logic dis_psgs;
        logic dis_regs;   // Hides ports EC and F0..F5
    } sysctrl_t;

    // UART FIFO interface
    typedef struct packed {
        logic [8:0] data;   // Bit 8 set sends a break
        logic       wr;
    } esp_tx_t;

    typedef struct packed {
        logic [8:0] data;   // Bit 8 set on a received break
        logic       empty;
        logic       tx_full;
        logic       overflow;
        logic       framing_err;
    } esp_rx_t;

    // Decoded UART strobes from the I/O block
    typedef struct packed {
        logic ctrl_wr;
        logic data_wr;
        logic data_rd;
    } esp_sel_t;

    typedef logic [13:0] mix_t;
    typedef logic [15:0] sample_t;
    typedef logic [63:0] keys_t;   // 8 rows of 8, active low

endpackage

`default_nettype wire

// File: bank_mapper.sv
`default_nettype none
`timescale 1ns/1ps

`include "aqp_defines.svh"

module bank_mapper (
    input  wire                    clk,
    input  wire                    reset,
    input  wire bus_pkg::bus_req_t ebus,
    input  wire                    bank_wr,
    output bus_pkg::bank_reg_t     bank_rd,
    output bus_pkg::mem_ctrl_t     mem
);
    import bus_pkg::*;

    bank_reg_t bank_q [4];      // One per 16 KB CPU quarter
    bank_reg_t cur_bank;
    page_t     page;
    logic      bank_ro;
    logic      bank_overlay;
    logic      sel_ram;
    logic      sel_cart;
    logic      sel_sysram;

    ////////////////////////////////////////////////////////////////////////
    // Page registers
    ////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                bank_q[i] <= '0;
            end
        end else if (bank_wr) begin
            bank_q[ebus.addr[1:0]] <= ebus.wrdata;
        end
    end

    // Port F0..F3 readback, low address bits pick the register
    assign bank_rd = bank_q[ebus.addr[1:0]];

    ////////////////////////////////////////////////////////////////////////
    // Memory decode
    ////////////////////////////////////////////////////////////////////////
    assign cur_bank     = bank_q[ebus.addr[15:14]];
    assign page         = cur_bank[5:0];
    assign bank_ro      = cur_bank[7];
    assign bank_overlay = cur_bank[6];

    // Pages 32..63 are RAM
    assign sel_ram  = !ebus.mreq_n && page[5];
    assign sel_cart = !ebus.mreq_n && (page[5:2] == `AQP_PAGE_CART_HI);

    // System RAM stays writable under the overlay, even with read-only set
    assign sel_sysram = bank_overlay && (ebus.addr[13:11] == `AQP_SYSRAM_BLK);

    always_comb begin
        mem.ba        = page[4:0];
        mem.ram_ce_n  = !sel_ram;
        mem.cart_ce_n = !sel_cart;
        mem.ram_we_n  = !(sel_ram && !ebus.wr_n && (!bank_ro || sel_sysram));
    end

endmodule

`default_nettype wire

// File: io_regs.sv
`default_nettype none
`timescale 1ns/1ps

`include "aqp_defines.svh"

module io_regs (
    input  wire                       clk,
    input  wire                       reset,
    input  wire bus_pkg::bus_req_t    ebus,
    input  wire bus_pkg::bank_reg_t   bank_rd,
    input  wire bus_pkg::data_t       esp_ctrl_rd,
    input  wire bus_pkg::data_t       esp_data_rd,
    input  wire periph_pkg::keys_t    keys,
    input  wire                       cassette_in,
    input  wire                       printer_in,
    output logic                      bank_wr,
    output periph_pkg::esp_sel_t      esp_sel,
    output bus_pkg::data_t            d_out,
    output logic                      d_oe,
    output periph_pkg::sysctrl_t      sysctrl,
    output bus_pkg::data_t            dac,
    output logic                      cassette_out,
    output logic                      printer_out,
    output logic                      reset_req
);
    import bus_pkg::*;
    import periph_pkg::*;

    localparam data_t PORT_BANK = `AQP_IO_BANK_BASE;

    logic       bus_read;
    logic       bus_write;
    logic       io_cyc;
    data_t      port;
    logic       sel_dac;
    logic       sel_bank;
    logic       sel_espctrl;
    logic       sel_espdata;
    logic       sel_sysctrl;
    logic       sel_cassette;
    logic       sel_printer;
    logic       sel_keyb;
    logic       sel_any;
    logic [2:0] cassette_sync;
    logic [2:0] printer_sync;
    data_t      kb_data;

    assign bus_read  = !ebus.rd_n && ebus.stb;
    assign bus_write = !ebus.wr_n && ebus.stb;
    assign io_cyc    = !ebus.iorq_n;
    assign port      = ebus.addr[7:0];

    ////////////////////////////////////////////////////////////////////////
    // Port decode
    ////////////////////////////////////////////////////////////////////////
    // Hidden while dis_regs is set
    assign sel_dac     = io_cyc && !sysctrl.dis_regs && port == `AQP_IO_DAC;
    assign sel_bank    = io_cyc && !sysctrl.dis_regs && port[7:2] == PORT_BANK[7:2];
    assign sel_espctrl = io_cyc && !sysctrl.dis_regs && port == `AQP_IO_ESPCTRL;
    assign sel_espdata = io_cyc && !sysctrl.dis_regs && port == `AQP_IO_ESPDATA;

    // Always visible
    assign sel_sysctrl  = io_cyc && port == `AQP_IO_SYSCTRL;
    assign sel_cassette = io_cyc && port == `AQP_IO_CASSETTE;
    assign sel_printer  = io_cyc && port == `AQP_IO_PRINTER;
    assign sel_keyb     = io_cyc && port == `AQP_IO_KEYB;

    assign sel_any = sel_dac | sel_bank | sel_espctrl | sel_espdata |
                     sel_sysctrl | sel_cassette | sel_printer | sel_keyb;

    assign bank_wr = sel_bank && bus_write;
    assign esp_sel = '{ctrl_wr: sel_espctrl && bus_write,
                       data_wr: sel_espdata && bus_write,
                       data_rd: sel_espdata && bus_read};

    ////////////////////////////////////////////////////////////////////////
    // Registers and input synchronizers
    ////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sysctrl       <= '0;
            dac           <= '0;
            cassette_out  <= 1'b0;
            printer_out   <= 1'b0;
            reset_req     <= 1'b0;
            cassette_sync <= '0;
            printer_sync  <= '0;
        end else begin
            cassette_sync <= {cassette_sync[1:0], cassette_in};
            printer_sync  <= {printer_sync[1:0], printer_in};

            // Single cycle pulse after a sysctrl write with bit 7 set
            reset_req <= sel_sysctrl && bus_write && ebus.wrdata[7];

            if (sel_sysctrl && bus_write) sysctrl <= sysctrl_t'(ebus.wrdata[3:0]);
            if (sel_dac && bus_write) dac <= ebus.wrdata;
            if (sel_cassette && bus_write) cassette_out <= ebus.wrdata[0];
            if (sel_printer && bus_write) printer_out <= ebus.wrdata[0];
        end
    end

    // Keyboard scan, a low address bit selects the row
    always_comb begin
        kb_data = 8'hFF;
        for (int n = 0; n < 8; n++) begin
            if (!ebus.addr[8 + n]) kb_data = kb_data & keys[8 * n +: 8];
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Read mux
    ////////////////////////////////////////////////////////////////////////
    always_comb begin
        d_out = 8'hFF;
        if (sel_dac)      d_out = dac;
        if (sel_bank)     d_out = bank_rd;
        if (sel_espctrl)  d_out = esp_ctrl_rd;
        if (sel_espdata)  d_out = esp_data_rd;
        if (sel_sysctrl)  d_out = {4'b0000, sysctrl};          // Bit 7 reads 0
        if (sel_cassette) d_out = {7'b0, !cassette_sync[2]};
        if (sel_printer)  d_out = {7'b0, printer_sync[2]};
        if (sel_keyb)     d_out = kb_data;
    end

    assign d_oe = !ebus.rd_n && sel_any;

endmodule

`default_nettype wire

// File: esp_uart_bridge.sv
`default_nettype none
`timescale 1ns/1ps

module esp_uart_bridge (
    input  wire                       clk,
    input  wire                       reset,
    input  wire periph_pkg::esp_sel_t esp_sel,
    input  wire bus_pkg::data_t       wrdata,
    input  wire periph_pkg::esp_rx_t  rx,
    output periph_pkg::esp_tx_t       tx,
    output logic                      rx_rd,
    output bus_pkg::data_t            ctrl_rd,
    output bus_pkg::data_t            data_rd
);

    logic overflow_q;   // Sticky RX FIFO overflow
    logic framing_q;    // Sticky framing error

    ////////////////////////////////////////////////////////////////////////
    // FIFO strobes
    ////////////////////////////////////////////////////////////////////////
    // A ctrl write with bit 7 set queues a break
    assign tx.data = esp_sel.ctrl_wr ? 9'h100 : {1'b0, wrdata};
    assign tx.wr   = esp_sel.data_wr || (esp_sel.ctrl_wr && wrdata[7]);
    assign rx_rd   = esp_sel.data_rd;     // Pop on data port read

    ////////////////////////////////////////////////////////////////////////
    // Error flags
    ////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            overflow_q <= 1'b0;
            framing_q  <= 1'b0;
        end else begin
            // Write 1 to clear
            if (esp_sel.ctrl_wr) begin
                overflow_q <= overflow_q & ~wrdata[4];
                framing_q  <= framing_q & ~wrdata[3];
            end

            // New errors win over a clear in the same cycle
            if (rx.overflow) overflow_q <= 1'b1;
            if (rx.framing_err) framing_q <= 1'b1;
        end
    end

    assign ctrl_rd = {3'b000, overflow_q, framing_q, rx.data[8], rx.tx_full, !rx.empty};
    assign data_rd = rx.data[7:0];

endmodule

`default_nettype wire

// File: audio_mixer.sv
`default_nettype none
`timescale 1ns/1ps

`include "aqp_defines.svh"

module audio_mixer (
    input  wire                  clk,
    input  wire bus_pkg::data_t  dac,
    input  wire                  cassette_out,
    output periph_pkg::sample_t  audio_out
);
    import periph_pkg::*;

    mix_t mix;
    mix_t beep;

    // Cassette output doubles as the system beep
    assign beep = cassette_out ? mix_t'(`AQP_BEEP_LEVEL) : '0;

    // DAC sits 4 bits up so it matches the old PSG channel scale
    assign mix = {2'b00, dac, 4'b0000} + beep;

    // Offset binary to signed, padded to 16 bits
    always_ff @(posedge clk) begin
        audio_out <= {~mix[13], mix[12:0], 2'b00};
    end

endmodule

`default_nettype wire

// File: aqp_bus_top.sv
`default_nettype none
`timescale 1ns/1ps

module aqp_bus_top (
    input  wire                      clk,
    input  wire                      reset,
    input  wire bus_pkg::bus_req_t   ebus,
    input  wire periph_pkg::keys_t   keys,
    input  wire periph_pkg::esp_rx_t esp_rx,
    input  wire                      cassette_in,
    input  wire                      printer_in,
    output bus_pkg::data_t           d_out,
    output logic                     d_oe,
    output bus_pkg::mem_ctrl_t       mem,
    output periph_pkg::esp_tx_t      esp_tx,
    output logic                     esp_rx_rd,
    output periph_pkg::sample_t      audio_out,
    output logic                     cassette_out,
    output logic                     printer_out,
    output logic                     turbo,
    output logic                     turbo_unlimited,
    output logic                     reset_req
);
    import bus_pkg::*;
    import periph_pkg::*;

    logic      bank_wr;
    bank_reg_t bank_rd;
    esp_sel_t  esp_sel;
    data_t     esp_ctrl_rd;
    data_t     esp_data_rd;
    sysctrl_t  sysctrl;
    data_t     dac;

    bank_mapper u_bank_mapper (
        .clk     (clk),
        .reset   (reset),
        .ebus    (ebus),
        .bank_wr (bank_wr),
        .bank_rd (bank_rd),
        .mem     (mem)
    );

    io_regs u_io_regs (
        .clk          (clk),
        .reset        (reset),
        .ebus         (ebus),
        .bank_rd      (bank_rd),
        .esp_ctrl_rd  (esp_ctrl_rd),
        .esp_data_rd  (esp_data_rd),
        .keys         (keys),
        .cassette_in  (cassette_in),
        .printer_in   (printer_in),
        .bank_wr      (bank_wr),
        .esp_sel      (esp_sel),
        .d_out        (d_out),
        .d_oe         (d_oe),
        .sysctrl      (sysctrl),
        .dac          (dac),
        .cassette_out (cassette_out),
        .printer_out  (printer_out),
        .reset_req    (reset_req)
    );

    esp_uart_bridge u_esp_uart_bridge (
        .clk     (clk),
        .reset   (reset),
        .esp_sel (esp_sel),
        .wrdata  (ebus.wrdata),
        .rx      (esp_rx),
        .tx      (esp_tx),
        .rx_rd   (esp_rx_rd),
        .ctrl_rd (esp_ctrl_rd),
        .data_rd (esp_data_rd)
    );

    audio_mixer u_audio_mixer (
        .clk          (clk),
        .dac          (dac),
        .cassette_out (cassette_out),
        .audio_out    (audio_out)
    );

    assign turbo           = sysctrl.turbo;
    assign turbo_unlimited = sysctrl.turbo_unlimited;

endmodule

`default_nettype wire

// File: tb_aqp_bus_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "aqp_defines.svh"

module tb_aqp_bus_top;
    import bus_pkg::*;
    import periph_pkg::*;

    localparam int ROUNDS   = 8;
    localparam int ACCESSES = 16;
    localparam int UART_CYC = 64;
    // Reset, mapping and protection, readback, keyboard, UART, audio, then margin
    localparam int MAX_CYCLES = 17 + 2 * ROUNDS * (8 + ACCESSES) + 19 + 11 * ROUNDS
                              + 4 * ROUNDS + UART_CYC + 4 + 11 * ROUNDS + 100;

    logic      clk = 1'b0;
    logic      reset;
    bus_req_t  ebus;
    keys_t     keys;
    esp_rx_t   esp_rx;
    logic      cassette_in;
    logic      printer_in;
    data_t     d_out;
    logic      d_oe;
    mem_ctrl_t mem;
    esp_tx_t   esp_tx;
    logic      esp_rx_rd;
    sample_t   audio_out;
    logic      cassette_out;
    logic      printer_out;
    logic      turbo;
    logic      turbo_unlimited;
    logic      reset_req;

    logic [15:0] lfsr = 16'd192;
    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;
    int          test_checks = 0;
    int          test_errors = 0;

    // Reference model state
    bank_reg_t   bank_m [4];
    data_t       dac_m = '0;
    logic        cas_m = 1'b0;
    logic [3:0]  sys_m = '0;
    logic        ovf_m = 1'b0;     // Sticky UART flags
    logic        frm_m = 1'b0;

    aqp_bus_top dut (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////
    // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            r = {r[62:0], lfsr[0]};
        end
        return r;
    endfunction

    // Memory cycle when io is low and a strobe is given
    function automatic bus_req_t make_bus(input addr_t a, input data_t wd, input logic rd,
                                          input logic wr, input logic io);
        return {a, wd, ~rd, ~wr, io | ~(rd | wr), ~io, rd | wr};
    endfunction

    function automatic sample_t audio_model(input data_t dac, input logic cas);
        logic [13:0] sum;
        sum = 14'(dac) * 14'd16 + (cas ? 14'(`AQP_BEEP_LEVEL) : 14'd0);
        return {~sum[13], sum[12:0], 2'b00};
    endfunction

    task automatic check_eq(input string what, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        test_checks++;
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic report_test(input string name);
        $display("%s: %0d checks, %0d errors", name, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic io_write(input data_t port, input data_t wd);
        @(negedge clk);
        ebus = make_bus({8'(rand_bits(8)), port}, wd, 1'b0, 1'b1, 1'b1);
        @(negedge clk);
        ebus = make_bus('0, '0, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic read_check(input data_t port, input data_t exp_d, input logic exp_oe,
                              input string what);
        @(negedge clk);
        ebus = make_bus({8'(rand_bits(8)), port}, '0, 1'b1, 1'b0, 1'b1);
        #1;
        check_eq(what, d_out, exp_d);
        check_eq({what, " d_oe"}, d_oe, exp_oe);
        // No memory chip is enabled without mreq_n
        check_eq("chip enables in I/O cycle",
                 {mem.ram_ce_n, mem.cart_ce_n, mem.ram_we_n}, 3'b111);
    endtask

    task automatic fill_banks();
        data_t v;
        for (int i = 0; i < 4; i++) begin
            v = 8'(rand_bits(8));
            io_write(`AQP_IO_BANK_BASE + 8'(i), v);
            bank_m[i] = v;
        end
    endtask

    task automatic mem_check(input logic wr, input logic in_sysram);
        addr_t     a;
        bank_reg_t b;
        a = 16'(rand_bits(16));
        if (in_sysram) a[13:11] = `AQP_SYSRAM_BLK;
        b = bank_m[a[15:14]];
        @(negedge clk);
        ebus = make_bus(a, 8'(rand_bits(8)), !wr, wr, 1'b0);
        #1;
        check_eq("ba", mem.ba, b[4:0]);
        check_eq("ram_ce_n", mem.ram_ce_n, !b[5]);
        check_eq("cart_ce_n", mem.cart_ce_n, b[5:2] != `AQP_PAGE_CART_HI);
        // Writable page, or system RAM under the overlay
        check_eq("ram_we_n", mem.ram_we_n,
                 !(wr && b[5] && (!b[7] || (b[6] && a[13:11] == `AQP_SYSRAM_BLK))));
    endtask

    // op 0 idle, 1 data write, 2 ctrl write, 3 data read, 4 ctrl read
    task automatic uart_cycle(input int op, input data_t wd, input esp_rx_t rx);
        logic  send;
        data_t port;
        send = (op == 1) || (op == 2 && wd[7]);
        port = (op == 2 || op == 4) ? `AQP_IO_ESPCTRL : `AQP_IO_ESPDATA;
        @(negedge clk);
        esp_rx = rx;
        ebus = make_bus({8'h00, port}, wd, op >= 3, op == 1 || op == 2, op != 0);
        #1;
        check_eq("tx wr", esp_tx.wr, send);
        if (send) check_eq("tx data", esp_tx.data, op == 2 ? 9'h100 : {1'b0, wd});
        check_eq("rx_rd", esp_rx_rd, op == 3);
        if (op == 3) check_eq("rx data", d_out, rx.data[7:0]);
        if (op == 4) begin
            check_eq("uart status", d_out,
                     {3'b000, ovf_m, frm_m, rx.data[8], rx.tx_full, !rx.empty});
        end
        // Flags as they stand after the coming edge
        if (op == 2) begin
            ovf_m = ovf_m & !wd[4];
            frm_m = frm_m & !wd[3];
        end
        if (rx.overflow) ovf_m = 1'b1;
        if (rx.framing_err) frm_m = 1'b1;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        data_t   v;
        data_t   hi;
        logic    c;
        logic    p;
        logic    cas_sync;
        logic    prn_sync;
        int      op;
        sample_t old;
        esp_rx_t rx;
        ebus = make_bus('0, '0, 1'b0, 1'b0, 1'b0);
        keys = '1;
        esp_rx = '0;
        esp_rx.empty = 1'b1;
        cassette_in = 1'b0;
        printer_in = 1'b0;
        cas_sync = 1'b0;
        prn_sync = 1'b0;
        reset = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        check_eq("outputs after reset",
                 {reset_req, turbo, turbo_unlimited, cassette_out, printer_out, esp_rx_rd}, '0);
        repeat (ROUNDS) begin
            fill_banks();
            repeat (ACCESSES) mem_check(1'b0, 1'b0);
        end
        report_test("Test 1 bank mapping");

        repeat (ROUNDS) begin
            fill_banks();
            repeat (ACCESSES) mem_check(1'b1, 1'(rand_bits(1)));
        end
        report_test("Test 2 write protection");

        for (int i = 0; i < 4; i++) begin
            read_check(`AQP_IO_BANK_BASE + 8'(i), bank_m[i], 1'b1, "bank readback");
        end
        repeat (ROUNDS) begin
            v = 8'(rand_bits(8)) & 8'hFE;     // dis_regs stays clear
            io_write(`AQP_IO_SYSCTRL, v);
            sys_m = v[3:0];
            #1;
            check_eq("reset_req pulse", reset_req, v[7]);
            check_eq("turbo outputs", {turbo_unlimited, turbo}, sys_m[3:2]);
            @(negedge clk);
            #1;
            check_eq("reset_req end", reset_req, 1'b0);
            read_check(`AQP_IO_SYSCTRL, {4'b0000, sys_m}, 1'b1, "sysctrl readback");
            dac_m = 8'(rand_bits(8));
            io_write(`AQP_IO_DAC, dac_m);
            read_check(`AQP_IO_DAC, dac_m, 1'b1, "dac readback");
            cas_m = 1'(rand_bits(1));
            c = 1'(rand_bits(1));
            io_write(`AQP_IO_CASSETTE, {7'(rand_bits(7)), cas_m});
            io_write(`AQP_IO_PRINTER, {7'(rand_bits(7)), c});
            check_eq("cassette and printer out", {cassette_out, printer_out}, {cas_m, c});
        end
        // Hide EC and F0..F5
        io_write(`AQP_IO_SYSCTRL, {4'b0000, sys_m[3:1], 1'b1});
        read_check(`AQP_IO_DAC, 8'hFF, 1'b0, "hidden dac");
        for (int i = 0; i < 6; i++) begin
            read_check(8'hF0 + 8'(i), 8'hFF, 1'b0, "hidden port");
        end
        read_check(`AQP_IO_SYSCTRL, {4'b0000, sys_m[3:1], 1'b1}, 1'b1, "sysctrl while hidden");
        io_write(`AQP_IO_BANK_BASE, ~bank_m[0]);   // Ignored while hidden
        io_write(`AQP_IO_SYSCTRL, {4'b0000, sys_m});
        read_check(`AQP_IO_BANK_BASE, bank_m[0], 1'b1, "bank after hidden write");
        report_test("Test 3 register readback");

        repeat (4 * ROUNDS) begin
            @(negedge clk);
            keys = rand_bits(64);
            hi = 8'(rand_bits(8));
            ebus = make_bus({hi, `AQP_IO_KEYB}, '0, 1'b1, 1'b0, 1'b1);
            #1;
            v = 8'hFF;
            for (int n = 0; n < 8; n++) begin
                v = v & (hi[n] ? 8'hFF : keys[8 * n +: 8]);
            end
            check_eq("keyboard scan", d_out, v);
            check_eq("keyboard d_oe", d_oe, 1'b1);
        end
        report_test("Test 4 keyboard scan");

        repeat (UART_CYC) begin
            rx.data = 9'(rand_bits(9));
            rx.empty = 1'(rand_bits(1));
            rx.tx_full = 1'(rand_bits(1));
            rx.overflow = (rand_bits(3) == 0);
            rx.framing_err = (rand_bits(3) == 0);
            op = int'(rand_bits(3) % 5);
            uart_cycle(op, 8'(rand_bits(8)), rx);
        end
        // New errors beat a clear in the same cycle
        rx = '0;
        rx.overflow = 1'b1;
        rx.framing_err = 1'b1;
        uart_cycle(2, 8'h18, rx);
        rx = '0;
        uart_cycle(4, 8'h00, rx);
        uart_cycle(2, 8'h18, rx);
        uart_cycle(4, 8'h00, rx);
        report_test("Test 5 UART bridge");

        repeat (2 * ROUNDS) begin
            old = audio_model(dac_m, cas_m);
            if (rand_bits(1) != 0) begin
                dac_m = 8'(rand_bits(8));
                io_write(`AQP_IO_DAC, dac_m);
            end else begin
                cas_m = 1'(rand_bits(1));
                io_write(`AQP_IO_CASSETTE, {7'b0, cas_m});
            end
            check_eq("audio before update", audio_out, old);
            @(negedge clk);
            check_eq("audio after update", audio_out, audio_model(dac_m, cas_m));
        end
        // Each round one input is read after two edges, the other after three
        for (int i = 0; i < ROUNDS; i++) begin
            @(negedge clk);
            c = 1'(rand_bits(1));
            p = 1'(rand_bits(1));
            cassette_in = c;
            printer_in = p;
            @(negedge clk);
            if (i % 2 == 0) begin
                read_check(`AQP_IO_CASSETTE, {7'b0, !cas_sync}, 1'b1,
                           "cassette after two edges");
                read_check(`AQP_IO_PRINTER, {7'b0, p}, 1'b1, "printer after three edges");
                read_check(`AQP_IO_CASSETTE, {7'b0, !c}, 1'b1, "cassette after four edges");
            end else begin
                read_check(`AQP_IO_PRINTER, {7'b0, prn_sync}, 1'b1,
                           "printer after two edges");
                read_check(`AQP_IO_CASSETTE, {7'b0, !c}, 1'b1, "cassette after three edges");
                read_check(`AQP_IO_PRINTER, {7'b0, p}, 1'b1, "printer after four edges");
            end
            cas_sync = c;
            prn_sync = p;
        end
        report_test("Test 6 audio");

        $display("Total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+.
bus_pkg.sv
periph_pkg.sv
bank_mapper.sv
io_regs.sv
esp_uart_bridge.sv
audio_mixer.sv
aqp_bus_top.sv
tb_aqp_bus_top.sv
